/* Makefile */
VERILATOR ?= verilator
TOP       := aesTb
FILELIST  := project.f
OBJDIR    := obj_dir
FLAGS     := --timing --assert -Wno-fatal
SIMFLAGS  := --binary -j 0 --Mdir $(OBJDIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run's exit status is the pass or fail result
sim:
	$(VERILATOR) $(SIMFLAGS) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

/* bench/aesRefModel.svh */
/* Standalone AES-128 encryption model and LCG for the testbench.
   Works on byte arrays with byte 0 in the top bits; needs aesBlockT and sBoxTable in scope. */
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

    // 32-bit linear congruential step
    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [7:0] refSbox(input logic [7:0] b);
        return sBoxTable[2047 - 8 * int'(b) -: 8];
    endfunction

    // shift-and-add multiply in GF(2^8)
    function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] x;
        logic [7:0] y;
        p = 8'h00;
        x = a;
        y = b;
        for (int i = 0; i < 8; i++) begin
            if (y[0]) begin
                p = p ^ x;
            end
            x = x[7] ? ((x << 1) ^ 8'h1b) : (x << 1);
            y = y >> 1;
        end
        return p;
    endfunction

    function automatic aesBlockT aesEncryptRef(input aesBlockT plain, input aesBlockT key);
        logic [31:0] w [44];
        logic [7:0] s [16];
        logic [7:0] t [16];
        logic [31:0] tmp;
        logic [7:0] rc;
        aesBlockT result;
        rc = 8'h01;
        for (int i = 0; i < 4; i++) begin
            w[i] = key[127 - 32 * i -: 32];
        end
        // whole key schedule expanded up front
        for (int i = 4; i < 44; i++) begin
            tmp = w[i - 1];
            if (i % 4 == 0) begin
                tmp = {refSbox(tmp[23:16]), refSbox(tmp[15:8]),
                       refSbox(tmp[7:0]), refSbox(tmp[31:24])} ^ {rc, 24'h0};
                rc = gfMul(rc, 8'h02);
            end
            w[i] = w[i - 4] ^ tmp;
        end
        for (int i = 0; i < 16; i++) begin
            s[i] = plain[127 - 8 * i -: 8] ^ w[i / 4][31 - 8 * (i % 4) -: 8];
        end
        for (int round = 1; round <= 10; round++) begin
            for (int i = 0; i < 16; i++) begin
                t[i] = refSbox(s[i]);
            end
            // state index is row + 4 * column
            for (int c = 0; c < 4; c++) begin
                for (int r = 0; r < 4; r++) begin
                    s[r + 4 * c] = t[r + 4 * ((c + r) % 4)];
                end
            end
            if (round < 10) begin
                for (int c = 0; c < 4; c++) begin
                    for (int r = 0; r < 4; r++) begin
                        t[4 * c + r] = gfMul(s[4 * c + r], 8'h02)
                            ^ gfMul(s[4 * c + (r + 1) % 4], 8'h03)
                            ^ s[4 * c + (r + 2) % 4] ^ s[4 * c + (r + 3) % 4];
                    end
                end
                s = t;
            end
            for (int i = 0; i < 16; i++) begin
                s[i] = s[i] ^ w[4 * round + i / 4][31 - 8 * (i % 4) -: 8];
            end
        end
        for (int i = 0; i < 16; i++) begin
            result[127 - 8 * i -: 8] = s[i];
        end
        return result;
    endfunction

`endif

/* bench/aesTb.sv */
/* Drives the pipelined AES-128 core through known answer, sink credit, random and
   back-pressure tests. The consumer model keeps at most CreditCap credits at the core. */
`timescale 1ns/10ps

module aesTb import aesPkg::*; ();

    localparam int BufferDepth = 16;
    localparam int InitialSinkCredits = 2;
    localparam int NumRandom = 300;
    localparam int CreditCap = 4;
    localparam int TotalBlocks = 1 + 4 + NumRandom + BufferDepth + CreditCap + 2;
    localparam int TimeoutCycles = 4 * TotalBlocks * 12 + 1000;
    localparam int DrainCycles = 4 * 12 * (BufferDepth + CreditCap);

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic inValid = 1'b0;
    aesBlockT inBlock = '0;
    aesBlockT inKey = '0;
    logic inReady;
    logic outValid;
    aesBlockT outBlock;
    logic outCredit = 1'b0;

    aesBlockT expQ [$];
    aesBlockT lastOut = '0;
    int acceptedCount = 0;
    int receivedCount = 0;
    int grantedCount = 0;
    int cycleCount = 0;
    int sinkHeld = InitialSinkCredits;
    logic creditsOn = 1'b0;
    logic [31:0] stimRng = 32'd90;
    logic [31:0] creditRng = 32'd90;

    `include "aesRefModel.svh"

    aesEncryptPipe DUT (
        .clk       (clk),
        .rst       (rst),
        .inValid   (inValid),
        .inBlock   (inBlock),
        .inKey     (inKey),
        .inReady   (inReady),
        .outValid  (outValid),
        .outBlock  (outBlock),
        .outCredit (outCredit)
    );

    always #2 clk = ~clk;

    task automatic failStop(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compareBlock(input aesBlockT actual, input aesBlockT expected,
                                input string what);
        if (actual !== expected) begin
            failStop($sformatf("Mismatch at %0t: %s expected %h got %h",
                $time, what, expected, actual));
        end
    endtask

    task automatic compareCount(input int actual, input int expected, input string what);
        if (actual !== expected) begin
            failStop($sformatf("Mismatch at %0t: %s expected %0d got %0d",
                $time, what, expected, actual));
        end
    endtask

    task automatic compareBit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            failStop($sformatf("Mismatch at %0t: %s expected %b got %b",
                $time, what, expected, actual));
        end
    endtask

    function automatic logic [31:0] randWord();
        stimRng = lcgNext(stimRng);
        return stimRng;
    endfunction

    function automatic aesBlockT randBlock();
        return {randWord(), randWord(), randWord(), randWord()};
    endfunction

    // holds the block on the bus until the edge that takes it
    task automatic sendBlock(input aesBlockT block, input aesBlockT key);
        inValid <= 1'b1;
        inBlock <= block;
        inKey <= key;
        @(posedge clk);
        while (!inReady) begin
            @(posedge clk);
        end
    endtask

    // waits for every accepted block to come out, bounded by DrainCycles
    task automatic waitDrain();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (receivedCount != acceptedCount && waited < DrainCycles);
    endtask

    // consumer model grants credits while it holds fewer than CreditCap at the core
    always @(posedge clk) begin
        if (rst) begin
            outCredit <= 1'b0;
            sinkHeld = InitialSinkCredits;
        end else begin
            if (outCredit) begin
                sinkHeld = sinkHeld + 1;
            end
            if (outValid) begin
                sinkHeld = sinkHeld - 1;
            end
            creditRng = lcgNext(creditRng);
            outCredit <= creditsOn && (sinkHeld < CreditCap) && creditRng[29];
        end
    end

    always @(posedge clk) begin : scoreboard
        aesBlockT expected;
        int grantedNow;
        if (!rst) begin
            if (inValid && inReady) begin
                expQ.push_back(aesEncryptRef(inBlock, inKey));
                acceptedCount <= acceptedCount + 1;
            end
            grantedNow = grantedCount + int'(outCredit);
            grantedCount <= grantedNow;
            if (outValid) begin
                if (expQ.size() == 0) begin
                    failStop("an output block appeared with no accepted block outstanding");
                end else begin
                    expected = expQ.pop_front();
                    compareBlock(outBlock, expected, "output block");
                    lastOut <= outBlock;
                    receivedCount <= receivedCount + 1;
                    if (receivedCount + 1 > InitialSinkCredits + grantedNow) begin
                        failStop("more blocks left the core than sink credits allow");
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            failStop($sformatf("timeout after %0d cycles, the core stopped making progress",
                cycleCount));
        end
    end

    initial begin : stimulus
        aesBlockT katKey;
        aesBlockT katPlain;
        aesBlockT katCipher;
        int available;
        int phaseStart;
        int held;
        katKey = 128'h000102030405060708090a0b0c0d0e0f;
        katPlain = 128'h00112233445566778899aabbccddeeff;
        katCipher = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        compareBit(outValid, 1'b0, "outValid after reset");
        compareBit(inReady, 1'b1, "inReady after reset");

        compareBlock(aesEncryptRef(katPlain, katKey), katCipher, "reference known answer");
        sendBlock(katPlain, katKey);
        inValid <= 1'b0;
        waitDrain();
        compareBlock(lastOut, katCipher, "core known answer");

        // only the reset credits may be spent before any grant
        repeat (4) sendBlock(randBlock(), randBlock());
        inValid <= 1'b0;
        repeat (30) @(posedge clk);
        compareCount(receivedCount, InitialSinkCredits, "blocks out with no credit granted");
        creditsOn <= 1'b1;
        waitDrain();
        compareCount(receivedCount, acceptedCount, "blocks out once credits were granted");

        for (int i = 0; i < NumRandom; i++) begin
            if ((randWord() >> 30) == 0) begin
                inValid <= 1'b0;
                @(posedge clk);
            end
            sendBlock(randBlock(), randBlock());
        end
        inValid <= 1'b0;
        waitDrain();
        compareCount(receivedCount, acceptedCount, "blocks out after random traffic");

        // offer a block every cycle while output credits are withheld
        creditsOn <= 1'b0;
        repeat (4) @(posedge clk);
        available = InitialSinkCredits + grantedCount - receivedCount;
        phaseStart = acceptedCount;
        repeat (BufferDepth + available + 40) begin
            inValid <= 1'b1;
            inBlock <= randBlock();
            inKey <= randBlock();
            @(posedge clk);
        end
        inValid <= 1'b0;
        @(posedge clk);
        held = acceptedCount - phaseStart;
        compareBit(inReady, 1'b0, "inReady with output credits withheld");
        if (held > BufferDepth + available) begin
            failStop($sformatf("core took %0d blocks under back-pressure, limit is %0d",
                held, BufferDepth + available));
        end
        creditsOn <= 1'b1;
        waitDrain();
        compareCount(receivedCount, acceptedCount, "blocks out after credits resumed");

        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* design/aesEgress.sv */
/* Final round into a result buffer, popped one block per cycle under sink credit.
   ResultFifoDepth must be a power of two; the consumer may hold at most 255 credits.
   The ingress credit loop keeps the buffer from overflowing, nothing here checks it. */
`timescale 1ns/10ps

module aesEgress import aesPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     prevValid,
    input  aesBlockT prevState,
    input  aesBlockT prevKey,
    output logic     creditReturn,
    input  logic     outCredit,
    output logic     outValid,
    output aesBlockT outBlock
);

    aesBlockT finalBlock;
    aesBlockT mem [ResultFifoDepth];
    logic [$clog2(ResultFifoDepth)-1:0] wrPtr;
    logic [$clog2(ResultFifoDepth)-1:0] rdPtr;
    resultCreditT count;
    sinkCreditT sinkCount;
    logic push;
    logic pop;

    // last round has no MixColumns
    assign finalBlock = shiftRows(subBytes(prevState)) ^ nextRoundKey(prevKey, NumRounds);
    assign push = prevValid;

    // the block now on the output still owns one credit
    assign pop = (count != '0) && (sinkCount > sinkCreditT'(outValid));
    assign creditReturn = pop;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= finalBlock;
        end
        if (pop) begin
            outBlock <= mem[rdPtr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            outValid <= 1'b0;
        end else begin
            outValid <= pop;
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (!push && pop) begin
                count <= count - 1'b1;
            end
        end
    end

    // credits granted by the consumer, spent as each block leaves
    always_ff @(posedge clk) begin
        if (rst) begin
            sinkCount <= sinkCreditT'(SinkCredits);
        end else begin
            case ({outCredit, outValid})
                2'b10: sinkCount <= sinkCount + 1'b1;
                2'b01: sinkCount <= sinkCount - 1'b1;
                default: sinkCount <= sinkCount;
            endcase
        end
    end

    // ingress credits bound everything in flight plus held to the depth
    assert property (@(posedge clk) disable iff (rst)
        push |-> count < resultCreditT'(ResultFifoDepth));

    assert property (@(posedge clk) disable iff (rst)
        outValid |-> sinkCount != '0);

    assert property (@(posedge clk) disable iff (rst)
        (sinkCount == '1) |-> !(outCredit && !outValid));

endmodule

/* design/aesEncryptPipe.sv */
/* Fully pipelined AES-128 encryptor, one block per cycle.
   Input is valid/ready; output is credit based with no ready, SinkCredits held at reset. */
`timescale 1ns/10ps

module aesEncryptPipe import aesPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     inValid,
    input  aesBlockT inBlock,
    input  aesBlockT inKey,
    output logic     inReady,
    output logic     outValid,
    output aesBlockT outBlock,
    input  logic     outCredit
);

    // stage 0 is the whitened state, stage n the output of round n
    logic     stageValid [NumRounds];
    aesBlockT stageState [NumRounds];
    aesBlockT stageKey [NumRounds];
    logic     creditReturn;

    aesIngress ingress (
        .clk          (clk),
        .rst          (rst),
        .inValid      (inValid),
        .inBlock      (inBlock),
        .inKey        (inKey),
        .inReady      (inReady),
        .creditReturn (creditReturn),
        .stateValid   (stageValid[0]),
        .state        (stageState[0]),
        .roundKey     (stageKey[0])
    );

    for (genvar r = 1; r < NumRounds; r++) begin : genRound
        aesRound #(.roundIndex(r)) round (
            .clk        (clk),
            .rst        (rst),
            .prevValid  (stageValid[r-1]),
            .prevState  (stageState[r-1]),
            .prevKey    (stageKey[r-1]),
            .stateValid (stageValid[r]),
            .state      (stageState[r]),
            .roundKey   (stageKey[r])
        );
    end

    aesEgress egress (
        .clk          (clk),
        .rst          (rst),
        .prevValid    (stageValid[NumRounds-1]),
        .prevState    (stageState[NumRounds-1]),
        .prevKey      (stageKey[NumRounds-1]),
        .creditReturn (creditReturn),
        .outCredit    (outCredit),
        .outValid     (outValid),
        .outBlock     (outBlock)
    );

endmodule

/* design/aesIngress.sv */
/* Pipeline entry: accepts a block while result-buffer credit remains and whitens it.
   creditReturn must pulse once per block popped from the egress buffer. */
`timescale 1ns/10ps

module aesIngress import aesPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     inValid,
    input  aesBlockT inBlock,
    input  aesBlockT inKey,
    output logic     inReady,
    input  logic     creditReturn,
    output logic     stateValid,
    output aesBlockT state,
    output aesBlockT roundKey
);

    resultCreditT creditCount;
    logic accept;

    assign inReady = (creditCount != '0);
    assign accept = inValid && inReady;

    // free slots in the result buffer, counting blocks still in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            creditCount <= resultCreditT'(ResultFifoDepth);
            stateValid <= 1'b0;
        end else begin
            stateValid <= accept;
            if (accept && !creditReturn) begin
                creditCount <= creditCount - 1'b1;
            end else if (!accept && creditReturn) begin
                creditCount <= creditCount + 1'b1;
            end
        end
    end

    // initial AddRoundKey, the raw key becomes round key 0
    always_ff @(posedge clk) begin
        if (accept) begin
            state <= inBlock ^ inKey;
            roundKey <= inKey;
        end
    end

    // a return without a matching earlier spend would break the loop
    assert property (@(posedge clk) disable iff (rst)
        creditCount <= resultCreditT'(ResultFifoDepth));

endmodule

/* design/aesPkg.sv */
/* AES-128 encryption constants, types and round transforms.
   Byte 0 of a block or key sits in bits [127:120]; columns are filled byte 0..3 first. */
package aesPkg;

    localparam int BlockBits = 128;
    localparam int NumRounds = 10;
    localparam int ResultFifoDepth = 16;
    localparam int SinkCredits = 2;

    typedef logic [BlockBits-1:0] aesBlockT;
    typedef logic [4:0] resultCreditT;
    typedef logic [7:0] sinkCreditT;

    // forward S-box, entry 0 in the top byte
    localparam logic [2047:0] sBoxTable = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // rcon for rounds 1..10, round 1 in the top byte
    localparam logic [79:0] roundConst = 80'h01020408102040801b36;

    function automatic logic [7:0] sBoxLookup(input logic [7:0] b);
        return sBoxTable[(255 - int'(b)) * 8 +: 8];
    endfunction

    // doubling in GF(2^8), no multiplier needed
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (8'h1b & {8{b[7]}});
    endfunction

    function automatic aesBlockT subBytes(input aesBlockT s);
        aesBlockT r;
        for (int i = 0; i < 16; i++) begin
            r[i*8 +: 8] = sBoxLookup(s[i*8 +: 8]);
        end
        return r;
    endfunction

    function automatic aesBlockT shiftRows(input aesBlockT s);
        aesBlockT r;
        int src;
        for (int c = 0; c < 4; c++) begin
            for (int row = 0; row < 4; row++) begin
                // row n rotates left by n columns
                src = row + 4 * ((c + row) % 4);
                r[(15 - (row + 4 * c)) * 8 +: 8] = s[(15 - src) * 8 +: 8];
            end
        end
        return r;
    endfunction

    function automatic aesBlockT mixColumns(input aesBlockT s);
        aesBlockT r;
        logic [7:0] a0, a1, a2, a3;
        for (int c = 0; c < 4; c++) begin
            a0 = s[(15 - 4 * c) * 8 +: 8];
            a1 = s[(14 - 4 * c) * 8 +: 8];
            a2 = s[(13 - 4 * c) * 8 +: 8];
            a3 = s[(12 - 4 * c) * 8 +: 8];
            // times 3 is xtime plus the byte itself
            r[(15 - 4 * c) * 8 +: 8] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
            r[(14 - 4 * c) * 8 +: 8] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
            r[(13 - 4 * c) * 8 +: 8] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
            r[(12 - 4 * c) * 8 +: 8] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
        end
        return r;
    endfunction

    // one key-schedule step, round is 1..NumRounds
    function automatic aesBlockT nextRoundKey(input aesBlockT k, input int round);
        logic [31:0] w0, w1, w2, w3, t;
        logic [7:0] rcon;
        w0 = k[127:96];
        w1 = k[95:64];
        w2 = k[63:32];
        w3 = k[31:0];
        rcon = roundConst[(NumRounds - round) * 8 +: 8];
        t = {sBoxLookup(w3[23:16]), sBoxLookup(w3[15:8]),
             sBoxLookup(w3[7:0]), sBoxLookup(w3[31:24])} ^ {rcon, 24'h0};
        w0 = w0 ^ t;
        w1 = w1 ^ w0;
        w2 = w2 ^ w1;
        w3 = w3 ^ w2;
        return {w0, w1, w2, w3};
    endfunction

endpackage

/* design/aesRound.sv */
/* One full AES round, registered, with its own key-schedule step.
   roundIndex selects the round constant and must lie in 1..9. */
`timescale 1ns/10ps

module aesRound import aesPkg::*; #(
    parameter int roundIndex = 1
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     prevValid,
    input  aesBlockT prevState,
    input  aesBlockT prevKey,
    output logic     stateValid,
    output aesBlockT state,
    output aesBlockT roundKey
);

    aesBlockT keyNext;
    aesBlockT mixed;

    assign keyNext = nextRoundKey(prevKey, roundIndex);
    assign mixed = mixColumns(shiftRows(subBytes(prevState)));

    always_ff @(posedge clk) begin
        if (rst) begin
            stateValid <= 1'b0;
        end else begin
            stateValid <= prevValid;
        end
    end

    // payload advances every cycle, valid marks the live slots
    always_ff @(posedge clk) begin
        state <= mixed ^ keyNext;
        roundKey <= keyNext;
    end

endmodule

/* project.f */
+incdir+bench
design/aesPkg.sv
design/aesIngress.sv
design/aesRound.sv
design/aesEgress.sv
design/aesEncryptPipe.sv
bench/aesTb.sv
